// ==== flist.f ====
+incdir+source
source/mport_pkg.sv
source/ui_fifo.sv
source/port_window.sv
source/burst_arbiter.sv
source/cmd_issuer.sv
source/wdata_sequencer.sv
source/rdata_tracker.sv
source/chan_occupancy.sv
source/mport_top.sv
test/ui_mem_model.sv
test/tb_mport.sv

// ==== Bender.yml ====
package:
  name: mport

export_include_dirs:
  - source

sources:
  - source/mport_pkg.sv
  - source/ui_fifo.sv
  - source/port_window.sv
  - source/burst_arbiter.sv
  - source/cmd_issuer.sv
  - source/wdata_sequencer.sv
  - source/rdata_tracker.sv
  - source/chan_occupancy.sv
  - source/mport_top.sv
  - target: test
    files:
      - test/ui_mem_model.sv
      - test/tb_mport.sv

// ==== test/tb_mport.sv ====
`include "mport_defines.svh"

module tb_mport;
	timeunit 1ns;
	timeprecision 1ps;

	localparam int PERIOD = 8;
	localparam int BEATS = `MP_BURST_BEATS;
	localparam int CMDS = `MP_BURST_BEATS / 2;
	localparam int SPAN = CMDS * `MP_CMD_STEP; // address covered by one burst
	localparam int DEPTH = `MP_FIFO_DEPTH;
	localparam int WORDS = 160; // per channel, whole bursts only
	localparam int WATCHDOG_NS = 40 * (2 * WORDS) * PERIOD;
	localparam logic [31:0] SEED = 32'hce00fccb;

	logic ui_clk, rst, calib;
	mport_pkg::ui_word_t wr_data [2];
	logic [1:0] wr_valid, win_load, rd_en;
	mport_pkg::ui_addr_t win_base [2];
	mport_pkg::ui_addr_t win_max [2];
	mport_pkg::beat_cnt_t thresh [2];
	wire [1:0] wr_full, rd_empty, ch_ready;
	wire mport_pkg::ui_word_t rd_data [2];
	wire mport_pkg::beat_cnt_t occ [2];

	logic app_en, app_rdy, app_wdf_wren, app_wdf_end, app_wdf_rdy, app_rd_data_valid;
	mport_pkg::ui_cmd_t app_cmd;
	mport_pkg::ui_addr_t app_addr;
	mport_pkg::ui_word_t app_wdf_data, app_rd_data;

	int pushed [2]; // words handed to each write port
	int popped [2]; // words taken from each read port
	int wr_seq [2]; // write beats seen at the UI
	int rd_ui [2]; // read beats seen at the UI
	int prev_occ [2];
	int limit [2]; // window size in beats, keeps writes from lapping reads
	int cmd_idx, wbeat_idx, n_mismatch, n_other;
	mport_pkg::ui_addr_t exp_win0; // expected window address of channel 0 writes

	mport_top dut_i (.ui_clk(ui_clk), .rst(rst), .init_calib_complete(calib),
		.wr0_data(wr_data[0]), .wr1_data(wr_data[1]), .wr0_valid(wr_valid[0]),
		.wr1_valid(wr_valid[1]), .wr0_full(wr_full[0]), .wr1_full(wr_full[1]),
		.wr0_load(win_load[0]), .wr1_load(win_load[1]), .wr0_base(win_base[0]),
		.wr1_base(win_base[1]), .wr0_max(win_max[0]), .wr1_max(win_max[1]),
		.rd0_data(rd_data[0]), .rd1_data(rd_data[1]), .rd0_en(rd_en[0]), .rd1_en(rd_en[1]),
		.rd0_empty(rd_empty[0]), .rd1_empty(rd_empty[1]), .rd0_load(win_load[0]),
		.rd1_load(win_load[1]), .rd0_base(win_base[0]), .rd1_base(win_base[1]),
		.rd0_max(win_max[0]), .rd1_max(win_max[1]), .ch0_thresh(thresh[0]),
		.ch1_thresh(thresh[1]), .app_en(app_en), .app_cmd(app_cmd), .app_addr(app_addr),
		.app_rdy(app_rdy), .app_wdf_data(app_wdf_data), .app_wdf_wren(app_wdf_wren),
		.app_wdf_end(app_wdf_end), .app_wdf_rdy(app_wdf_rdy), .app_rd_data(app_rd_data),
		.app_rd_data_valid(app_rd_data_valid), .occ0(occ[0]), .occ1(occ[1]),
		.ch0_ready(ch_ready[0]), .ch1_ready(ch_ready[1]));

	ui_mem_model mem_i (.ui_clk(ui_clk), .rst(rst), .app_en(app_en), .app_cmd(app_cmd),
		.app_addr(app_addr), .app_rdy(app_rdy), .app_wdf_data(app_wdf_data),
		.app_wdf_wren(app_wdf_wren), .app_wdf_rdy(app_wdf_rdy), .app_rd_data(app_rd_data),
		.app_rd_data_valid(app_rd_data_valid));

	always #(PERIOD / 2) ui_clk = ~ui_clk;

	// expected word number seq of a channel, tag byte on top
	function automatic mport_pkg::ui_word_t pattern_word(input int chan, input int seq);
		mport_pkg::ui_word_t w;
		int i;
		for (i = 0; i < 8; i++) w[i*32 +: 32] = (seq * 32'h9e3779b1) ^ (i * 32'h01010101) ^
			(chan * 32'h5a5a0000);
		w[255:248] = 8'hc0 | 8'(chan); // bit 248 names the channel
		return w;
	endfunction

	// window step after a burst
	function automatic mport_pkg::ui_addr_t next_window_addr(input mport_pkg::ui_addr_t addr,
		input mport_pkg::ui_addr_t base, input mport_pkg::ui_addr_t max);
		if (addr < max - SPAN) return addr + SPAN;
		return base;
	endfunction

	task automatic flag_mismatch(input string test, input logic [255:0] exp,
		input logic [255:0] act);
		n_mismatch++;
		$display("Mismatch %s expected %0h actual %0h at %0t", test, exp, act, $time);
	endtask

	task automatic note_failure(input string msg);
		n_other++;
		$display("%s at %0t", msg, $time);
	endtask

	// one word per cycle at most, honours full and the window limit
	task automatic feed_channel(input int chan, input int count, input bit gaps);
		int sent;
		sent = 0;
		while (sent < count) begin
			@(negedge ui_clk);
			if (!wr_full[chan] && pushed[chan] - popped[chan] < limit[chan] &&
				(!gaps || $urandom % 3 != 0)) begin
				wr_data[chan] = pattern_word(chan, pushed[chan]);
				wr_valid[chan] = 1'b1;
				pushed[chan]++;
				sent++;
			end else begin
				wr_valid[chan] = 1'b0;
			end
		end
		@(negedge ui_clk);
		wr_valid[chan] = 1'b0;
	endtask

	// read ports drained with random gaps
	always @(negedge ui_clk) begin : drain_reads
		int c;
		for (c = 0; c < 2; c++) rd_en[c] = !rst && !rd_empty[c] && ($urandom % 4 != 0);
	end

	// everything accepted at this edge, seen before the DUT updates
	always @(posedge ui_clk) begin : ui_compare
		int c;
		mport_pkg::ui_word_t want;
		mport_pkg::ui_addr_t want_addr;
		bit in0, in1;
		if (!rst) begin
			if (app_en && app_rdy) begin
				in0 = app_addr >= win_base[0] && app_addr < win_max[0];
				in1 = app_addr >= win_base[1] && app_addr < win_max[1];
				assert (in0 || in1) else note_failure($sformatf(
					"command address %0h lies outside both windows", app_addr));
				if (in0 && app_cmd == mport_pkg::CMD_WRITE) begin
					want_addr = exp_win0 + mport_pkg::ui_addr_t'(cmd_idx * `MP_CMD_STEP);
					assert (app_addr == want_addr) else flag_mismatch("window_wrap", want_addr, app_addr);
					cmd_idx++;
					if (cmd_idx == CMDS) begin // burst done, window moves on
						cmd_idx = 0;
						exp_win0 = next_window_addr(exp_win0, win_base[0], win_max[0]);
					end
				end
			end
			if (app_wdf_wren && app_wdf_rdy) begin
				c = app_wdf_data[248];
				want = pattern_word(c, wr_seq[c]);
				assert (app_wdf_data == want) else flag_mismatch("write_order", want, app_wdf_data);
				assert (app_wdf_end == (wbeat_idx % 2 == 1)) else
					flag_mismatch("wdf_end", wbeat_idx % 2 == 1, app_wdf_end);
				wr_seq[c]++;
				wbeat_idx = (wbeat_idx + 1) % BEATS;
			end
			if (app_rd_data_valid) rd_ui[app_rd_data[248]]++;
			for (c = 0; c < 2; c++) begin
				if (rd_en[c] && !rd_empty[c]) begin
					want = pattern_word(c, popped[c]);
					assert (rd_data[c] == want) else
						flag_mismatch(c == 0 ? "loopback_ch0" : "interleave_ch1", want, rd_data[c]);
					popped[c]++;
				end
			end
		end
	end

	// registered status, stable at the falling edge
	always @(negedge ui_clk) begin : status_compare
		int c;
		int want_occ;
		if (!rst) begin
			for (c = 0; c < 2; c++) begin
				want_occ = wr_seq[c] - rd_ui[c];
				assert (occ[c] == want_occ) else flag_mismatch("occupancy", want_occ, occ[c]);
				assert (ch_ready[c] == (prev_occ[c] > thresh[c])) else
					flag_mismatch("ready", prev_occ[c] > thresh[c], ch_ready[c]);
				prev_occ[c] = want_occ; // ready lags one cycle
			end
			if (!calib) assert (!app_en && !app_wdf_wren) else
				note_failure("UI request raised before calibration was complete");
		end
	end

	initial begin : watchdog
		#(WATCHDOG_NS);
		$display("watchdog expired with %0d and %0d of %0d words read back",
			popped[0], popped[1], WORDS);
		$display("test failed");
		$finish;
	end

	initial begin : main_flow
		int c;
		void'($urandom(SEED));
		ui_clk = 1'b0;
		rst = 1'b1;
		calib = 1'b0;
		wr_valid = '0;
		win_load = '0;
		rd_en = '0;
		win_base[0] = 'h1000; // four bursts, wraps often
		win_max[0] = 'h1080;
		win_base[1] = 'h8000;
		win_max[1] = 'h8400;
		thresh[0] = 12;
		thresh[1] = 20;
		for (c = 0; c < 2; c++) begin
			wr_data[c] = '0;
			pushed[c] = 0;
			popped[c] = 0;
			wr_seq[c] = 0;
			rd_ui[c] = 0;
			prev_occ[c] = 0;
			limit[c] = (win_max[c] - win_base[c]) / SPAN * BEATS;
		end
		exp_win0 = win_base[0];
		cmd_idx = 0;
		wbeat_idx = 0;
		n_mismatch = 0;
		n_other = 0;
		repeat (3) @(posedge ui_clk);
		@(negedge ui_clk);
		rst = 1'b0;
		@(negedge ui_clk);
		win_load = 2'b11;
		@(negedge ui_clk);
		win_load = 2'b00;
		// write FIFOs filled while calibration is still pending
		fork
			feed_channel(0, DEPTH, 1'b0);
			feed_channel(1, DEPTH, 1'b0);
		join
		repeat (20) @(negedge ui_clk);
		assert (wr_full == 2'b11) else note_failure("write FIFOs not full before calibration");
		calib = 1'b1;
		fork
			feed_channel(0, WORDS - DEPTH, 1'b1);
			feed_channel(1, WORDS - DEPTH, 1'b1);
		join
		wait (popped[0] == WORDS && popped[1] == WORDS);
		repeat (20) @(negedge ui_clk);
		for (c = 0; c < 2; c++) begin
			assert (wr_seq[c] == WORDS && rd_ui[c] == WORDS) else note_failure($sformatf(
				"channel %0d moved %0d words out and %0d back, not %0d", c, wr_seq[c],
				rd_ui[c], WORDS));
		end
		$display("checks done with %0d mismatches and %0d other errors", n_mismatch, n_other);
		if (n_mismatch + n_other == 0)
			$display("test passed");
		else
			$display("test failed");
		$finish;
	end

endmodule

// ==== test/ui_mem_model.sv ====
`include "mport_defines.svh"

module ui_mem_model (
	input  logic                ui_clk,
	input  logic                rst,
	input  logic                app_en,
	input  mport_pkg::ui_cmd_t  app_cmd,
	input  mport_pkg::ui_addr_t app_addr,
	output logic                app_rdy,
	input  mport_pkg::ui_word_t app_wdf_data,
	input  logic                app_wdf_wren,
	output logic                app_wdf_rdy,
	output mport_pkg::ui_word_t app_rd_data,
	output logic                app_rd_data_valid
);
	timeunit 1ns;
	timeprecision 1ps;

	mport_pkg::ui_word_t mem [logic [`MP_ADDR_W:0]]; // command address plus beat index
	mport_pkg::ui_addr_t wr_cmds [$]; // write commands waiting for data
	mport_pkg::ui_word_t wr_beats [$];
	mport_pkg::ui_word_t rd_beats [$]; // read data in command order
	int rd_due [$]; // cycle from which each beat may return
	int cyc;

	initial begin
		app_rdy = 1'b0;
		app_wdf_rdy = 1'b0;
		app_rd_data = '0;
		app_rd_data_valid = 1'b0;
		cyc = 0;
	end

	// commands and write beats taken at the rising edge
	always @(posedge ui_clk) begin : accept_side
		mport_pkg::ui_addr_t a;
		logic [`MP_ADDR_W:0] key;
		int due;
		int b;
		if (rst) begin
			wr_cmds.delete();
			wr_beats.delete();
			rd_beats.delete();
			rd_due.delete();
			cyc = 0;
		end else begin
			cyc++;
			if (app_en && app_rdy) begin
				if (app_cmd == mport_pkg::CMD_WRITE) begin
					wr_cmds.push_back(app_addr);
				end else begin
					due = cyc + 3 + $urandom % 8; // random read latency
					for (b = 0; b < 2; b++) begin
						key = {app_addr, b[0]};
						rd_beats.push_back(mem.exists(key) ? mem[key] : '0);
						rd_due.push_back(due);
					end
				end
			end
			if (app_wdf_wren && app_wdf_rdy) wr_beats.push_back(app_wdf_data);
			while (wr_cmds.size() > 0 && wr_beats.size() >= 2) begin // command and both beats in
				a = wr_cmds.pop_front();
				mem[{a, 1'b0}] = wr_beats.pop_front();
				mem[{a, 1'b1}] = wr_beats.pop_front();
			end
		end
	end

	// ready stalls and read return, driven on the falling edge
	always @(negedge ui_clk) begin : drive_side
		if (rst) begin
			app_rdy = 1'b0;
			app_wdf_rdy = 1'b0;
			app_rd_data_valid = 1'b0;
		end else begin
			app_rdy = $urandom % 4 != 0; // stall about one cycle in four
			app_wdf_rdy = $urandom % 3 != 0;
			if (rd_beats.size() > 0 && cyc >= rd_due[0]) begin
				app_rd_data = rd_beats.pop_front();
				void'(rd_due.pop_front());
				app_rd_data_valid = 1'b1;
			end else begin
				app_rd_data_valid = 1'b0;
			end
		end
	end

endmodule

// ==== source/mport_top.sv ====
module mport_top (
	input  logic                 ui_clk,
	input  logic                 rst,
	input  logic                 init_calib_complete,
	// write ports
	input  mport_pkg::ui_word_t  wr0_data,
	input  mport_pkg::ui_word_t  wr1_data,
	input  logic                 wr0_valid,
	input  logic                 wr1_valid,
	output logic                 wr0_full,
	output logic                 wr1_full,
	input  logic                 wr0_load,
	input  logic                 wr1_load,
	input  mport_pkg::ui_addr_t  wr0_base,
	input  mport_pkg::ui_addr_t  wr1_base,
	input  mport_pkg::ui_addr_t  wr0_max,
	input  mport_pkg::ui_addr_t  wr1_max,
	// read ports
	output mport_pkg::ui_word_t  rd0_data,
	output mport_pkg::ui_word_t  rd1_data,
	input  logic                 rd0_en,
	input  logic                 rd1_en,
	output logic                 rd0_empty,
	output logic                 rd1_empty,
	input  logic                 rd0_load,
	input  logic                 rd1_load,
	input  mport_pkg::ui_addr_t  rd0_base,
	input  mport_pkg::ui_addr_t  rd1_base,
	input  mport_pkg::ui_addr_t  rd0_max,
	input  mport_pkg::ui_addr_t  rd1_max,
	input  mport_pkg::beat_cnt_t ch0_thresh,
	input  mport_pkg::beat_cnt_t ch1_thresh,
	// DDR3 UI
	output logic                 app_en,
	output mport_pkg::ui_cmd_t   app_cmd,
	output mport_pkg::ui_addr_t  app_addr,
	input  logic                 app_rdy,
	output mport_pkg::ui_word_t  app_wdf_data,
	output logic                 app_wdf_wren,
	output logic                 app_wdf_end,
	input  logic                 app_wdf_rdy,
	input  mport_pkg::ui_word_t  app_rd_data,
	input  logic                 app_rd_data_valid,
	// status
	output mport_pkg::beat_cnt_t occ0,
	output mport_pkg::beat_cnt_t occ1,
	output logic                 ch0_ready,
	output logic                 ch1_ready
);
	mport_pkg::port_sel_t grant;
	mport_pkg::ui_addr_t burst_addr;
	mport_pkg::ui_addr_t win_wr0, win_wr1, win_rd0, win_rd1;
	mport_pkg::ui_word_t head_wr0, head_wr1;
	mport_pkg::beat_cnt_t used_wr0, used_wr1, free_rd0, free_rd1;
	logic pop0, pop1, push0, push1; // UI side of the FIFOs
	logic wr_done, rd_done, cmds_sent;

	// write FIFOs, drained by the data sequencer
	ui_fifo wr_fifo0 (.ui_clk(ui_clk), .rst(rst), .push(wr0_valid), .push_data(wr0_data),
		.pop(pop0), .head(head_wr0), .full(wr0_full), .empty(), .used(used_wr0), .free());
	ui_fifo wr_fifo1 (.ui_clk(ui_clk), .rst(rst), .push(wr1_valid), .push_data(wr1_data),
		.pop(pop1), .head(head_wr1), .full(wr1_full), .empty(), .used(used_wr1), .free());

	// read FIFOs, filled from UI read data
	ui_fifo rd_fifo0 (.ui_clk(ui_clk), .rst(rst), .push(push0), .push_data(app_rd_data),
		.pop(rd0_en), .head(rd0_data), .full(), .empty(rd0_empty), .used(), .free(free_rd0));
	ui_fifo rd_fifo1 (.ui_clk(ui_clk), .rst(rst), .push(push1), .push_data(app_rd_data),
		.pop(rd1_en), .head(rd1_data), .full(), .empty(rd1_empty), .used(), .free(free_rd1));

	// windows step when their own burst ends
	port_window wr_win0 (.ui_clk(ui_clk), .rst(rst), .load(wr0_load), .base_addr(wr0_base),
		.max_addr(wr0_max), .advance(wr_done && grant == mport_pkg::SEL_WR0), .addr(win_wr0));
	port_window wr_win1 (.ui_clk(ui_clk), .rst(rst), .load(wr1_load), .base_addr(wr1_base),
		.max_addr(wr1_max), .advance(wr_done && grant == mport_pkg::SEL_WR1), .addr(win_wr1));
	port_window rd_win0 (.ui_clk(ui_clk), .rst(rst), .load(rd0_load), .base_addr(rd0_base),
		.max_addr(rd0_max), .advance(rd_done && grant == mport_pkg::SEL_RD0), .addr(win_rd0));
	port_window rd_win1 (.ui_clk(ui_clk), .rst(rst), .load(rd1_load), .base_addr(rd1_base),
		.max_addr(rd1_max), .advance(rd_done && grant == mport_pkg::SEL_RD1), .addr(win_rd1));

	burst_arbiter arb_i (.ui_clk(ui_clk), .rst(rst), .calib(init_calib_complete),
		.wr0_used(used_wr0), .wr1_used(used_wr1), .rd0_free(free_rd0), .rd1_free(free_rd1),
		.occ0(occ0), .occ1(occ1), .wr_done(wr_done), .rd_done(rd_done),
		.win_addr0_wr(win_wr0), .win_addr1_wr(win_wr1),
		.win_addr0_rd(win_rd0), .win_addr1_rd(win_rd1),
		.grant(grant), .burst_addr(burst_addr));

	cmd_issuer cmd_i (.ui_clk(ui_clk), .rst(rst), .grant(grant), .burst_addr(burst_addr),
		.app_rdy(app_rdy), .app_en(app_en), .app_cmd(app_cmd), .app_addr(app_addr),
		.cmds_sent(cmds_sent));

	wdata_sequencer wdata_i (.ui_clk(ui_clk), .rst(rst), .grant(grant),
		.fifo_head0(head_wr0), .fifo_head1(head_wr1), .app_wdf_rdy(app_wdf_rdy),
		.cmds_sent(cmds_sent), .app_wdf_data(app_wdf_data), .app_wdf_wren(app_wdf_wren),
		.app_wdf_end(app_wdf_end), .pop0(pop0), .pop1(pop1), .wr_done(wr_done));

	rdata_tracker rdata_i (.ui_clk(ui_clk), .rst(rst), .grant(grant),
		.app_rd_data_valid(app_rd_data_valid), .push0(push0), .push1(push1),
		.rd_done(rd_done));

	// memory fill per channel, counted at the UI
	chan_occupancy occ_ch0 (.ui_clk(ui_clk), .rst(rst), .wr_beat(pop0), .rd_beat(push0),
		.dma_thresh(ch0_thresh), .occ(occ0), .ready(ch0_ready));
	chan_occupancy occ_ch1 (.ui_clk(ui_clk), .rst(rst), .wr_beat(pop1), .rd_beat(push1),
		.dma_thresh(ch1_thresh), .occ(occ1), .ready(ch1_ready));

endmodule

// ==== source/chan_occupancy.sv ====
module chan_occupancy (
	input  logic                 ui_clk,
	input  logic                 rst,
	input  logic                 wr_beat,
	input  logic                 rd_beat,
	input  mport_pkg::beat_cnt_t dma_thresh,
	output mport_pkg::beat_cnt_t occ,
	output logic                 ready
);
	always_ff @(posedge ui_clk or posedge rst) begin
		if (rst) begin
			occ <= '0;
			ready <= 1'b0;
		end else begin
			case ({wr_beat, rd_beat})
				2'b10: occ <= occ + 1'b1; // beat written to memory
				2'b01: occ <= occ - 1'b1; // beat read back out
				default: occ <= occ;
			endcase
			ready <= occ > dma_thresh; // lags occ by one cycle
		end
	end

endmodule

// ==== source/rdata_tracker.sv ====
`include "mport_defines.svh"

module rdata_tracker (
	input  logic                 ui_clk,
	input  logic                 rst,
	input  mport_pkg::port_sel_t grant,
	input  logic                 app_rd_data_valid,
	output logic                 push0,
	output logic                 push1,
	output logic                 rd_done
);
	localparam int BEATS = `MP_BURST_BEATS;

	mport_pkg::beat_cnt_t beat_cnt; // read beats seen this burst
	logic beat;

	assign push0 = app_rd_data_valid & (grant == mport_pkg::SEL_RD0);
	assign push1 = app_rd_data_valid & (grant == mport_pkg::SEL_RD1);
	assign beat = push0 | push1;
	assign rd_done = beat && beat_cnt == BEATS - 1; // on the last beat itself

	always_ff @(posedge ui_clk or posedge rst) begin
		if (rst) beat_cnt <= '0;
		else if (rd_done) beat_cnt <= '0;
		else if (beat) beat_cnt <= beat_cnt + 1'b1;
	end

endmodule

// ==== source/wdata_sequencer.sv ====
`include "mport_defines.svh"

module wdata_sequencer (
	input  logic                 ui_clk,
	input  logic                 rst,
	input  mport_pkg::port_sel_t grant,
	input  mport_pkg::ui_word_t  fifo_head0,
	input  mport_pkg::ui_word_t  fifo_head1,
	input  logic                 app_wdf_rdy,
	input  logic                 cmds_sent,
	output mport_pkg::ui_word_t  app_wdf_data,
	output logic                 app_wdf_wren,
	output logic                 app_wdf_end,
	output logic                 pop0,
	output logic                 pop1,
	output logic                 wr_done
);
	localparam int BEATS = `MP_BURST_BEATS;

	typedef enum logic [1:0] {
		S_IDLE,
		S_DATA,
		S_WAIT
	} state_t;

	state_t state;
	mport_pkg::beat_cnt_t beat_cnt; // beats accepted this burst
	logic accept;

	assign app_wdf_wren = state == S_DATA;
	assign app_wdf_data = grant == mport_pkg::SEL_WR1 ? fifo_head1 : fifo_head0; // head held until pop
	assign app_wdf_end = app_wdf_wren & beat_cnt[0]; // every second beat
	assign accept = app_wdf_wren & app_wdf_rdy;
	assign pop0 = accept & (grant == mport_pkg::SEL_WR0);
	assign pop1 = accept & (grant == mport_pkg::SEL_WR1);
	assign wr_done = state == S_WAIT && cmds_sent; // data and commands both finished

	always_ff @(posedge ui_clk or posedge rst) begin
		if (rst) begin
			state <= S_IDLE;
			beat_cnt <= '0;
		end else begin
			case (state)
				S_IDLE: begin
					if (grant == mport_pkg::SEL_WR0 || grant == mport_pkg::SEL_WR1) begin
						beat_cnt <= '0;
						state <= S_DATA;
					end
				end
				S_DATA: begin
					if (accept) begin
						beat_cnt <= beat_cnt + 1'b1;
						if (beat_cnt == BEATS - 1) state <= S_WAIT; // last beat out
					end
				end
				default: begin
					if (cmds_sent) state <= S_IDLE; // wr_done pulses this cycle
				end
			endcase
		end
	end

endmodule

// ==== source/cmd_issuer.sv ====
`include "mport_defines.svh"

module cmd_issuer (
	input  logic                 ui_clk,
	input  logic                 rst,
	input  mport_pkg::port_sel_t grant,
	input  mport_pkg::ui_addr_t  burst_addr,
	input  logic                 app_rdy,
	output logic                 app_en,
	output mport_pkg::ui_cmd_t   app_cmd,
	output mport_pkg::ui_addr_t  app_addr,
	output logic                 cmds_sent
);
	localparam int CMDS = `MP_BURST_BEATS / 2; // two beats per command
	localparam mport_pkg::ui_addr_t STEP = mport_pkg::ui_addr_t'(`MP_CMD_STEP);

	typedef enum logic [1:0] {
		S_IDLE,
		S_ISSUE,
		S_WAIT_DONE
	} state_t;

	state_t state;
	mport_pkg::beat_cnt_t cmd_cnt; // commands accepted this burst
	logic is_read;

	assign is_read = grant == mport_pkg::SEL_RD0 || grant == mport_pkg::SEL_RD1;
	assign cmds_sent = state == S_WAIT_DONE; // all commands of the burst taken

	always_ff @(posedge ui_clk or posedge rst) begin
		if (rst) begin
			state <= S_IDLE;
			app_en <= 1'b0;
			cmd_cnt <= '0;
		end else begin
			case (state)
				S_IDLE: begin
					if (grant != mport_pkg::SEL_NONE) begin
						app_en <= 1'b1;
						cmd_cnt <= '0;
						state <= S_ISSUE;
					end
				end
				S_ISSUE: begin
					if (app_rdy) begin // accepted, else hold en/cmd/addr
						cmd_cnt <= cmd_cnt + 1'b1;
						if (cmd_cnt == CMDS - 1) begin
							app_en <= 1'b0;
							state <= S_WAIT_DONE;
						end
					end
				end
				default: begin
					if (grant == mport_pkg::SEL_NONE) state <= S_IDLE; // re-arm after grant drops
				end
			endcase
		end
	end

	always_ff @(posedge ui_clk) begin
		if (state == S_IDLE && grant != mport_pkg::SEL_NONE) begin
			app_cmd <= is_read ? mport_pkg::CMD_READ : mport_pkg::CMD_WRITE;
			app_addr <= burst_addr; // window address of granted port
		end else if (state == S_ISSUE && app_rdy) begin
			app_addr <= app_addr + STEP;
		end
	end

endmodule

// ==== source/burst_arbiter.sv ====
`include "mport_defines.svh"

module burst_arbiter (
	input  logic                  ui_clk,
	input  logic                  rst,
	input  logic                  calib,
	input  mport_pkg::beat_cnt_t  wr0_used,
	input  mport_pkg::beat_cnt_t  wr1_used,
	input  mport_pkg::beat_cnt_t  rd0_free,
	input  mport_pkg::beat_cnt_t  rd1_free,
	input  mport_pkg::beat_cnt_t  occ0,
	input  mport_pkg::beat_cnt_t  occ1,
	input  logic                  wr_done,
	input  logic                  rd_done,
	input  mport_pkg::ui_addr_t   win_addr0_wr,
	input  mport_pkg::ui_addr_t   win_addr1_wr,
	input  mport_pkg::ui_addr_t   win_addr0_rd,
	input  mport_pkg::ui_addr_t   win_addr1_rd,
	output mport_pkg::port_sel_t  grant,
	output mport_pkg::ui_addr_t   burst_addr
);
	localparam int BEATS = `MP_BURST_BEATS;

	logic wr0_ok, wr1_ok, rd0_ok, rd1_ok;
	logic grant_wr;
	mport_pkg::port_sel_t pick;
	mport_pkg::ui_addr_t pick_addr;

	assign wr0_ok = wr0_used >= BEATS; // a full burst waiting
	assign wr1_ok = wr1_used >= BEATS;
	assign rd0_ok = rd0_free >= BEATS && occ0 >= BEATS; // room here and data in memory
	assign rd1_ok = rd1_free >= BEATS && occ1 >= BEATS;
	assign grant_wr = grant == mport_pkg::SEL_WR0 || grant == mport_pkg::SEL_WR1;

	// fixed priority wr0, wr1, rd0, rd1
	always_comb begin
		pick = mport_pkg::SEL_NONE;
		pick_addr = '0;
		if (wr0_ok) begin
			pick = mport_pkg::SEL_WR0;
			pick_addr = win_addr0_wr;
		end else if (wr1_ok) begin
			pick = mport_pkg::SEL_WR1;
			pick_addr = win_addr1_wr;
		end else if (rd0_ok) begin
			pick = mport_pkg::SEL_RD0;
			pick_addr = win_addr0_rd;
		end else if (rd1_ok) begin
			pick = mport_pkg::SEL_RD1;
			pick_addr = win_addr1_rd;
		end
	end

	always_ff @(posedge ui_clk or posedge rst) begin
		if (rst) begin
			grant <= mport_pkg::SEL_NONE;
		end else if (grant == mport_pkg::SEL_NONE) begin
			if (calib) grant <= pick; // nothing starts before calibration
		end else if ((grant_wr && wr_done) || (!grant_wr && rd_done)) begin
			grant <= mport_pkg::SEL_NONE; // burst over, free next cycle
		end
	end

	always_ff @(posedge ui_clk) begin
		if (grant == mport_pkg::SEL_NONE) burst_addr <= pick_addr; // frozen during burst
	end

endmodule

// ==== source/port_window.sv ====
`include "mport_defines.svh"

module port_window (
	input  logic                ui_clk,
	input  logic                rst,
	input  logic                load,
	input  mport_pkg::ui_addr_t base_addr,
	input  mport_pkg::ui_addr_t max_addr,
	input  logic                advance,
	output mport_pkg::ui_addr_t addr
);
	// address covered by one burst of commands
	localparam mport_pkg::ui_addr_t SPAN =
		mport_pkg::ui_addr_t'((`MP_BURST_BEATS / 2) * `MP_CMD_STEP);

	mport_pkg::ui_addr_t base_q; // wrap target
	mport_pkg::ui_addr_t max_q;

	always_ff @(posedge ui_clk or posedge rst) begin
		if (rst) begin
			base_q <= '0;
			max_q <= '0;
			addr <= '0;
		end else if (load) begin // load wins over a burst end
			base_q <= base_addr;
			max_q <= max_addr;
			addr <= base_addr;
		end else if (advance) begin
			if (addr < max_q - SPAN) addr <= addr + SPAN; // room for another burst
			else addr <= base_q; // back to start of window
		end
	end

endmodule

// ==== source/ui_fifo.sv ====
`include "mport_defines.svh"

module ui_fifo #(
	parameter int DEPTH = `MP_FIFO_DEPTH
) (
	input  logic                  ui_clk,
	input  logic                  rst,
	input  logic                  push,
	input  logic [`MP_WORD_W-1:0] push_data,
	input  logic                  pop,
	output logic [`MP_WORD_W-1:0] head,
	output logic                  full,
	output logic                  empty,
	output logic [`MP_CNT_W-1:0]  used,
	output logic [`MP_CNT_W-1:0]  free
);
	localparam int AW = $clog2(DEPTH);
	localparam logic [AW:0] DEPTH_W = (AW + 1)'(DEPTH);

	logic [`MP_WORD_W-1:0] mem [DEPTH];
	logic [AW-1:0] wr_ptr, rd_ptr; // wrap on their own, depth is 2**AW
	logic [AW:0] count;
	logic do_push, do_pop;

	assign do_push = push & ~full; // push on full is dropped, source sees full
	assign do_pop = pop & ~empty;
	assign full = count == DEPTH_W;
	assign empty = count == '0;
	assign head = mem[rd_ptr]; // show-ahead
	assign used = {{(`MP_CNT_W - AW - 1){1'b0}}, count};
	assign free = {{(`MP_CNT_W - AW - 1){1'b0}}, DEPTH_W - count};

	always_ff @(posedge ui_clk) begin
		if (do_push) mem[wr_ptr] <= push_data;
	end

	always_ff @(posedge ui_clk or posedge rst) begin
		if (rst) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
		end else begin
			if (do_push) wr_ptr <= wr_ptr + 1'b1;
			if (do_pop) rd_ptr <= rd_ptr + 1'b1;
			case ({do_push, do_pop})
				2'b10: count <= count + 1'b1;
				2'b01: count <= count - 1'b1;
				default: count <= count; // idle or both at once
			endcase
		end
	end

endmodule

// ==== source/mport_pkg.sv ====
package mport_pkg;

	`include "mport_defines.svh"

	typedef logic [`MP_ADDR_W-1:0] ui_addr_t; // UI byte-ish address
	typedef logic [`MP_WORD_W-1:0] ui_word_t; // one data beat

	typedef logic [`MP_CNT_W-1:0] beat_cnt_t; // beats and FIFO levels

	// UI command codes
	typedef enum logic [2:0] {
		CMD_WRITE = 3'b000,
		CMD_READ  = 3'b001
	} ui_cmd_t;

	// who owns the UI right now
	typedef enum logic [2:0] {
		SEL_NONE,
		SEL_WR0,
		SEL_WR1,
		SEL_RD0,
		SEL_RD1
	} port_sel_t;

endpackage

// ==== source/mport_defines.svh ====
`ifndef MPORT_DEFINES_SVH
`define MPORT_DEFINES_SVH

// UI address width
`define MP_ADDR_W 29

// one UI beat
`define MP_WORD_W 256

// data beats per burst, two beats per command
`define MP_BURST_BEATS 8

// UI address step per command
`define MP_CMD_STEP 8

// entries per port FIFO, power of two
`define MP_FIFO_DEPTH 32

// beat counters and FIFO levels
`define MP_CNT_W 16

`endif
